/* src/idec_pkg.sv */
// instruction decode stage package
// shared widths, rv32 opcodes, the instruction word views
// and the packet types passed between fetch, decode and issue

package idec_pkg;

  //////////////////////////////
  // sizes and options
  //////////////////////////////

  localparam int unsigned XLEN   = 32;
  localparam int unsigned REG_AW = 5;

  localparam bit RV32M_EN = 1'b1;  // mul/div legal

  // capability mode only has the lower 16 registers
  localparam int unsigned PMODE_REG_LIMIT_BIT = 4;

  //////////////////////////////
  // opcodes and pipeline class
  //////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [1:0] {
    PL_ALU    = 2'b00,
    PL_MULT   = 2'b01,
    PL_LS     = 2'b10,
    PL_BRANCH = 2'b11   // also jal and jalr
  } pl_type_e;

  //////////////////////////////
  // instruction word
  //////////////////////////////

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0]       imm12;   // csr address or system function
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } insn_i_t;

  // same 32 bits, read as r-type or i-type
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
  } insn_u;

  //////////////////////////////
  // packets
  //////////////////////////////

  typedef struct packed {
    logic [31:0] base32;
    logic [32:0] top33;     // top can reach 2^32
    logic        perm_ex;
    logic        perm_sr;
    logic        valid;
    logic [2:0]  otype;     // nonzero means sealed
  } pcc_cap_t;

  typedef struct packed {
    insn_u           insn;
    logic [XLEN-1:0] pc;
    logic            is_comp;
    logic            pmode;   // capability mode
    pcc_cap_t        pcc;
  } fetch_pkt_t;

  typedef struct packed {
    logic valid;
    logic csrw;
    logic mret;
    logic dret;
    logic wfi;
    logic ebrk;
    logic ecall;
  } sysctl_t;

  typedef struct packed {
    logic illegal_insn;
    logic bound_vio;
    logic perm_vio;
  } dec_errs_t;

  typedef struct packed {
    insn_u             insn;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [1:0]        rf_ren;   // {b, a}
    logic              rf_we;
    pl_type_e          pl_type;
    sysctl_t           sysctl;
    dec_errs_t         errs;
    logic              any_err;
    logic [XLEN-1:0]   btarget;
    logic [XLEN-1:0]   pc_nxt;
  } dec_pkt_t;

endpackage

/* src/fetch_rx.sv */
// fetch receive side
// accepts one fetch packet per four-phase req/ack cycle
// into a single entry slot, holds off fetch while the slot is full

module fetch_rx import idec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       in_req_i,
  input  fetch_pkt_t in_pkt_i,
  output logic       in_ack_o,
  input  logic       slot_take_i,
  output fetch_pkt_t slot_pkt_o,
  output logic       slot_full_o
);

  logic       ack_q;
  logic       full_q;
  fetch_pkt_t slot_q;
  logic       capture;

  // fresh request only, ack must have returned low first
  assign capture = in_req_i & ~ack_q & ~full_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      full_q <= 1'b0;
    end else begin
      if (capture) ack_q <= 1'b1;
      else if (!in_req_i) ack_q <= 1'b0;  // req seen low

      if (capture) full_q <= 1'b1;
      else if (slot_take_i) full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) slot_q <= in_pkt_i;
  end

  assign in_ack_o    = ack_q;
  assign slot_pkt_o  = slot_q;
  assign slot_full_o = full_q;

endmodule

/* src/insn_decode.sv */
// rv32im instruction decoder
// major opcode and function field decode, illegal encoding detection,
// register enables and indices, pipeline class, system special cases,
// branch/jal target and sequential next pc

module insn_decode import idec_pkg::*; (
  input  fetch_pkt_t        pkt_i,
  output logic [REG_AW-1:0] rs1_o,
  output logic [REG_AW-1:0] rs2_o,
  output logic [REG_AW-1:0] rd_o,
  output logic [1:0]        rf_ren_o,
  output logic              rf_we_o,
  output pl_type_e          pl_type_o,
  output sysctl_t           sysctl_o,
  output logic              illegal_o,
  output logic              mret_o,
  output logic [XLEN-1:0]   btarget_o,
  output logic [XLEN-1:0]   pc_nxt_o
);

  insn_u           insn;
  logic [XLEN-1:0] word;
  opcode_e         opcode;
  pl_type_e        pl_type;
  logic            rf_ren_a, rf_ren_b, rf_we;
  logic            illegal_insn, illegal_reg, illegal_all;
  logic            ecall_insn, ebrk_insn, mret_insn, dret_insn, wfi_insn, csr_wr;
  logic [XLEN-1:0] imm_j, imm_b;

  assign insn   = pkt_i.insn;
  assign word   = insn;
  assign opcode = opcode_e'(insn.r.opcode);

  //////////////////////////////
  // opcode decode
  //////////////////////////////

  always_comb begin
    pl_type      = PL_ALU;
    rf_ren_a     = 1'b0;
    rf_ren_b     = 1'b0;
    rf_we        = 1'b0;
    illegal_insn = 1'b0;
    ecall_insn   = 1'b0;
    ebrk_insn    = 1'b0;
    mret_insn    = 1'b0;
    dret_insn    = 1'b0;
    wfi_insn     = 1'b0;
    csr_wr       = 1'b0;

    unique case (opcode)
      OPCODE_JAL: begin
        pl_type = PL_BRANCH;
        rf_we   = 1'b1;
      end
      OPCODE_JALR: begin
        pl_type      = PL_BRANCH;
        rf_ren_a     = 1'b1;
        rf_we        = 1'b1;
        illegal_insn = (insn.i.funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        pl_type      = PL_BRANCH;
        rf_ren_a     = 1'b1;
        rf_ren_b     = 1'b1;
        illegal_insn = (insn.r.funct3[2:1] == 2'b01);  // 010, 011 unused
      end
      OPCODE_LOAD: begin
        pl_type      = PL_LS;
        rf_ren_a     = 1'b1;
        rf_we        = 1'b1;
        illegal_insn = (insn.i.funct3[1:0] == 2'b11) || (insn.i.funct3 == 3'b110);
      end
      OPCODE_STORE: begin
        pl_type      = PL_LS;
        rf_ren_a     = 1'b1;
        rf_ren_b     = 1'b1;
        illegal_insn = insn.r.funct3[2] | (insn.r.funct3[1:0] == 2'b11);
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        rf_we = 1'b1;
      end
      OPCODE_OP_IMM: begin
        rf_ren_a = 1'b1;
        rf_we    = 1'b1;
        if (insn.r.funct3 == 3'b001) begin
          illegal_insn = (insn.r.funct7 != 7'b000_0000);   // slli
        end else if (insn.r.funct3 == 3'b101) begin
          illegal_insn = (insn.r.funct7 != 7'b000_0000) &&
                         (insn.r.funct7 != 7'b010_0000);   // srli, srai
        end
      end
      OPCODE_OP: begin
        rf_ren_a = 1'b1;
        rf_ren_b = 1'b1;
        rf_we    = 1'b1;
        if (insn.r.funct7 == 7'b000_0001) begin            // mul/div group
          pl_type      = PL_MULT;
          illegal_insn = ~RV32M_EN;
        end else if (insn.r.funct7 == 7'b010_0000) begin   // sub, sra
          illegal_insn = (insn.r.funct3 != 3'b000) && (insn.r.funct3 != 3'b101);
        end else begin
          illegal_insn = (insn.r.funct7 != 7'b000_0000);
        end
      end
      OPCODE_MISC_MEM: begin
        // fence is a nop, fence.i redirects to the next pc
        pl_type      = PL_BRANCH;
        illegal_insn = (insn.i.funct3[2:1] != 2'b00);
      end
      OPCODE_SYSTEM: begin
        if (insn.i.funct3 == 3'b000) begin
          pl_type = PL_BRANCH;
          unique case (insn.i.imm12)
            12'h000: ecall_insn   = 1'b1;
            12'h001: ebrk_insn    = 1'b1;
            12'h302: mret_insn    = 1'b1;
            12'h7b2: dret_insn    = 1'b1;
            12'h105: wfi_insn     = 1'b1;
            default: illegal_insn = 1'b1;
          endcase
          if (insn.i.rs1 != '0 || insn.i.rd != '0) illegal_insn = 1'b1;
        end else begin
          // csr access, set/clear with rs1 zero is read only
          pl_type      = PL_MULT;
          csr_wr       = ~(insn.i.funct3[1] && (insn.i.rs1 == '0));
          rf_ren_a     = ~insn.i.funct3[2];   // immediate forms use rs1 as uimm
          rf_we        = 1'b1;
          illegal_insn = (insn.i.funct3[1:0] == 2'b00);
        end
      end
      default: illegal_insn = 1'b1;
    endcase
  end

  //////////////////////////////
  // register indices
  //////////////////////////////

  assign illegal_reg = pkt_i.pmode & ((rf_ren_a & insn.r.rs1[PMODE_REG_LIMIT_BIT]) |
                                      (rf_ren_b & insn.r.rs2[PMODE_REG_LIMIT_BIT]) |
                                      (rf_we    & insn.r.rd[PMODE_REG_LIMIT_BIT]));
  assign illegal_all = illegal_insn | illegal_reg;

  assign rf_ren_o = {rf_ren_b & ~illegal_all, rf_ren_a & ~illegal_all};
  assign rf_we_o  = rf_we & ~illegal_all;

  assign rs1_o = rf_ren_o[0] ? insn.r.rs1 : '0;  // unused fields read as zero
  assign rs2_o = rf_ren_o[1] ? insn.r.rs2 : '0;
  assign rd_o  = rf_we_o     ? insn.r.rd  : '0;

  assign illegal_o = illegal_all;
  assign pl_type_o = pl_type;
  assign mret_o    = mret_insn;

  // special case path for the issue controller
  assign sysctl_o.valid = csr_wr | mret_insn | dret_insn | wfi_insn | ebrk_insn | ecall_insn;
  assign sysctl_o.csrw  = csr_wr;
  assign sysctl_o.mret  = mret_insn;
  assign sysctl_o.dret  = dret_insn;
  assign sysctl_o.wfi   = wfi_insn;
  assign sysctl_o.ebrk  = ebrk_insn;
  assign sysctl_o.ecall = ecall_insn;

  //////////////////////////////
  // targets
  //////////////////////////////

  assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
  assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};

  assign btarget_o = pkt_i.pc + ((opcode == OPCODE_JAL) ? imm_j : imm_b);
  assign pc_nxt_o  = pkt_i.pc + (pkt_i.is_comp ? XLEN'(2) : XLEN'(4));

endmodule

/* src/fetch_check.sv */
// capability fetch check
// compares the fetch address against pcc bounds and checks
// pcc permissions, seal and tag, active in capability mode only

module fetch_check import idec_pkg::*; (
  input  fetch_pkt_t pkt_i,
  input  logic       mret_i,
  output logic       bound_vio_o,
  output logic       perm_vio_o
);

  logic [33:0] hdrm;
  logic        hdrm_ge4, hdrm_ge2, hdrm_ok;
  logic        base_ok;
  logic        allow_all;

  // full 32-bit space, lets pc 0xffff_fffe fetch a 4-byte insn
  assign allow_all = (pkt_i.pcc.base32 == '0) & pkt_i.pcc.top33[32];

  // bytes left between pc and top, bit 33 set means pc above top
  assign hdrm     = {1'b0, pkt_i.pcc.top33} - {2'b00, pkt_i.pc};
  assign hdrm_ge4 = (|hdrm[32:2]) & ~hdrm[33];
  assign hdrm_ge2 = (|hdrm[32:1]) & ~hdrm[33];
  assign hdrm_ok  = allow_all | (pkt_i.is_comp ? hdrm_ge2 : hdrm_ge4);
  assign base_ok  = (pkt_i.pc >= pkt_i.pcc.base32);

  assign bound_vio_o = pkt_i.pmode & (~base_ok | ~hdrm_ok);

  assign perm_vio_o = pkt_i.pmode & (~pkt_i.pcc.perm_ex            |
                                     ~pkt_i.pcc.valid              |
                                     (pkt_i.pcc.otype != '0)       |
                                     (mret_i & ~pkt_i.pcc.perm_sr));  // mret needs sr

endmodule

/* src/issue_tx.sv */
// issue send side
// builds the decoded packet, takes it from the fetch slot into
// an output register and offers it over a four-phase req/ack

module issue_tx import idec_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              slot_full_i,
  input  fetch_pkt_t        slot_pkt_i,
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  input  logic [REG_AW-1:0] rd_i,
  input  logic [1:0]        rf_ren_i,
  input  logic              rf_we_i,
  input  pl_type_e          pl_type_i,
  input  sysctl_t           sysctl_i,
  input  logic              illegal_i,
  input  logic [XLEN-1:0]   btarget_i,
  input  logic [XLEN-1:0]   pc_nxt_i,
  input  logic              bound_vio_i,
  input  logic              perm_vio_i,
  output logic              slot_take_o,
  output logic              out_req_o,
  output dec_pkt_t          out_pkt_o,
  input  logic              out_ack_i
);

  dec_pkt_t dec_pkt;
  dec_pkt_t buf_q;
  logic     req_q;   // also marks the buffer as occupied
  logic     load;

  always_comb begin
    dec_pkt                   = '0;
    dec_pkt.insn              = slot_pkt_i.insn;
    dec_pkt.pc                = slot_pkt_i.pc;
    dec_pkt.rs1               = rs1_i;
    dec_pkt.rs2               = rs2_i;
    dec_pkt.rd                = rd_i;
    dec_pkt.rf_ren            = rf_ren_i;
    dec_pkt.rf_we             = rf_we_i;
    dec_pkt.pl_type           = pl_type_i;
    dec_pkt.sysctl            = sysctl_i;
    dec_pkt.errs.illegal_insn = illegal_i;
    dec_pkt.errs.bound_vio    = bound_vio_i;
    dec_pkt.errs.perm_vio     = perm_vio_i;
    dec_pkt.any_err           = illegal_i | bound_vio_i | perm_vio_i;
    dec_pkt.btarget           = btarget_i;
    dec_pkt.pc_nxt            = pc_nxt_i;
  end

  // buffer free and previous ack gone low
  assign load = slot_full_i & ~req_q & ~out_ack_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else if (load) begin
      req_q <= 1'b1;
    end else if (out_ack_i) begin
      req_q <= 1'b0;  // drop req, free buffer
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) buf_q <= dec_pkt;
  end

  assign slot_take_o = load;
  assign out_req_o   = req_q;
  assign out_pkt_o   = buf_q;

endmodule

/* src/idec_top.sv */
// instruction decode stage top
// fetch receive slot, combinational decode and capability check,
// registered issue side toward the execute pipeline

module idec_top import idec_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       in_req_i,
  input  fetch_pkt_t in_pkt_i,
  output logic       in_ack_o,
  output logic       out_req_o,
  output dec_pkt_t   out_pkt_o,
  input  logic       out_ack_i
);

  fetch_pkt_t        slot_pkt;
  logic              slot_full, slot_take;
  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [1:0]        rf_ren;
  logic              rf_we;
  pl_type_e          pl_type;
  sysctl_t           sysctl;
  logic              illegal, mret;
  logic [XLEN-1:0]   btarget, pc_nxt;
  logic              bound_vio, perm_vio;

  fetch_rx u_fetch_rx (
    .clk_i, .rst_n_i, .in_req_i, .in_pkt_i, .in_ack_o,
    .slot_take_i (slot_take),
    .slot_pkt_o  (slot_pkt),
    .slot_full_o (slot_full)
  );

  insn_decode u_insn_decode (
    .pkt_i     (slot_pkt),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rd_o      (rd),
    .rf_ren_o  (rf_ren),
    .rf_we_o   (rf_we),
    .pl_type_o (pl_type),
    .sysctl_o  (sysctl),
    .illegal_o (illegal),
    .mret_o    (mret),
    .btarget_o (btarget),
    .pc_nxt_o  (pc_nxt)
  );

  fetch_check u_fetch_check (
    .pkt_i       (slot_pkt),
    .mret_i      (mret),
    .bound_vio_o (bound_vio),
    .perm_vio_o  (perm_vio)
  );

  issue_tx u_issue_tx (
    .clk_i, .rst_n_i,
    .slot_full_i (slot_full),
    .slot_pkt_i  (slot_pkt),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rd_i        (rd),
    .rf_ren_i    (rf_ren),
    .rf_we_i     (rf_we),
    .pl_type_i   (pl_type),
    .sysctl_i    (sysctl),
    .illegal_i   (illegal),
    .btarget_i   (btarget),
    .pc_nxt_i    (pc_nxt),
    .bound_vio_i (bound_vio),
    .perm_vio_i  (perm_vio),
    .slot_take_o (slot_take),
    .out_req_o, .out_pkt_o, .out_ack_i
  );

endmodule

/* tb/idec_tb.sv */
// testbench for the instruction decode stage
// fetch packets from a test file on the four-phase input side,
// consumer with random ack delays, in-order check of each decoded packet

module idec_tb import idec_pkg::*; ();

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       in_req_i;
  fetch_pkt_t in_pkt_i;
  logic       in_ack_o;
  logic       out_req_o;
  dec_pkt_t   out_pkt_o;
  logic       out_ack_i;

  fetch_pkt_t stim_q[$];
  dec_pkt_t   exp_q[$];
  int         n_tests = 0;
  int         n_recv  = 0;
  int         errors  = 0;
  int         cycles  = 0;
  int         limit   = 100;
  int         seed    = 32'h6d06;

  idec_top uut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .in_req_i  (in_req_i),
    .in_pkt_i  (in_pkt_i),
    .in_ack_o  (in_ack_o),
    .out_req_o (out_req_o),
    .out_pkt_o (out_pkt_o),
    .out_ack_i (out_ack_i)
  );

  always #5 clk_i = ~clk_i;

  // run length bound, set from the number of tests
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, %0d of %0d packets received",
               cycles, n_recv, n_tests);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////////////
  // checker
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("FAILED %s in packet %0d: got %h, expected %h", name, n_recv, got, want);
    end
  endtask

  task automatic compare_pkt(input dec_pkt_t got, input dec_pkt_t want);
    check_val("insn",    32'(got.insn),    32'(want.insn));
    check_val("pc",      got.pc,           want.pc);
    check_val("rs1",     32'(got.rs1),     32'(want.rs1));
    check_val("rs2",     32'(got.rs2),     32'(want.rs2));
    check_val("rd",      32'(got.rd),      32'(want.rd));
    check_val("rf_ren",  32'(got.rf_ren),  32'(want.rf_ren));
    check_val("rf_we",   32'(got.rf_we),   32'(want.rf_we));
    check_val("pl_type", 32'(got.pl_type), 32'(want.pl_type));
    check_val("sysctl",  32'(got.sysctl),  32'(want.sysctl));
    check_val("errs",    32'(got.errs),    32'(want.errs));
    check_val("any_err", 32'(got.any_err), 32'(want.any_err));
    check_val("btarget", got.btarget,      want.btarget);
    check_val("pc_nxt",  got.pc_nxt,       want.pc_nxt);
  endtask

  //////////////////////////////
  // test file
  //////////////////////////////

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] pmode, comp, pc, insn, base, perms;
    logic [32:0] top;
    logic [31:0] rs1, rs2, rd, ren, we, pl, sys, errs, btarget, pc_nxt;
    fetch_pkt_t  pkt;
    dec_pkt_t    want;
    fd = $fopen("tb/idec_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test file tb/idec_tests.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  pmode, comp, pc, insn, base, top, perms,
                  rs1, rs2, rd, ren, we, pl, sys, errs, btarget, pc_nxt);
      if (n == 17) begin   // comment lines match nothing
        pkt             = '0;
        pkt.insn        = insn;
        pkt.pc          = pc;
        pkt.is_comp     = comp[0];
        pkt.pmode       = pmode[0];
        pkt.pcc.base32  = base;
        pkt.pcc.top33   = top;
        pkt.pcc.perm_ex = perms[5];
        pkt.pcc.perm_sr = perms[4];
        pkt.pcc.valid   = perms[3];
        pkt.pcc.otype   = perms[2:0];
        want            = '0;
        want.insn       = insn;
        want.pc         = pc;
        want.rs1        = rs1[4:0];
        want.rs2        = rs2[4:0];
        want.rd         = rd[4:0];
        want.rf_ren     = ren[1:0];
        want.rf_we      = we[0];
        want.pl_type    = pl_type_e'(pl[1:0]);
        want.sysctl     = sys[6:0];
        want.errs       = errs[2:0];
        want.any_err    = |errs[2:0];
        want.btarget    = btarget;
        want.pc_nxt     = pc_nxt;
        stim_q.push_back(pkt);
        exp_q.push_back(want);
        n_tests++;
      end
    end
    $fclose(fd);
    if (n_tests == 0) begin
      $display("the test file holds no tests");
      errors++;
    end
    limit = 20 * n_tests + 100;
  endtask

  //////////////////////////////
  // fetch side and consumer
  //////////////////////////////

  task automatic drive_all();
    foreach (stim_q[i]) begin
      @(negedge clk_i);
      in_pkt_i = stim_q[i];
      in_req_i = 1'b1;
      do @(negedge clk_i); while (!in_ack_o);
      in_req_i = 1'b0;
      do @(negedge clk_i); while (in_ack_o);   // ack back low
    end
  endtask

  task automatic consume_all();
    int unsigned delay;
    while (n_recv < n_tests) begin
      @(negedge clk_i);
      if (out_req_o) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_i);
        compare_pkt(out_pkt_o, exp_q[n_recv]);
        out_ack_i = 1'b1;
        do @(negedge clk_i); while (out_req_o);
        out_ack_i = 1'b0;
        n_recv++;
      end
    end
  endtask

  initial begin
    rst_n_i   = 1'b0;
    in_req_i  = 1'b0;
    in_pkt_i  = '0;
    out_ack_i = 1'b0;
    load_tests();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    fork
      drive_all();
      consume_all();
    join
    repeat (10) @(negedge clk_i);   // no duplicate may follow
    if (out_req_o) begin
      errors++;
      $display("an extra packet appeared after the last test");
    end
    $display("tests %0d, received %0d, errors %0d", n_tests, n_recv, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* tb/idec_tests.txt */
# pmode is_comp pc insn pcc_base pcc_top perms{ex,sr,valid,otype[2:0]}
# expected: rs1 rs2 rd rf_ren rf_we pl_type sysctl errs btarget pc_nxt
0 0 00001000 00510093 00000000 100000000 38 02 00 01 1 1 0 00 0 00001800 00001004
0 0 00001000 005201b3 00000000 100000000 38 04 05 03 3 1 0 00 0 00001802 00001004
0 0 00001000 02838333 00000000 100000000 38 07 08 06 3 1 1 00 0 00001026 00001004
0 0 00001000 0005a503 00000000 100000000 38 0b 00 0a 1 1 2 00 0 0000100a 00001004
0 0 00001000 00c6a223 00000000 100000000 38 0d 0c 00 3 0 2 00 0 00001004 00001004
0 0 00001000 fe209ce3 00000000 100000000 38 01 02 00 3 0 3 00 0 00000ff8 00001004
0 0 00001000 100000ef 00000000 100000000 38 00 00 01 0 1 3 00 0 00001100 00001004
0 0 00001000 000280e7 00000000 100000000 38 05 00 01 1 1 3 00 0 00001800 00001004
0 0 00001000 00001437 00000000 100000000 38 00 00 08 0 1 0 00 0 00001008 00001004
0 1 00002000 00000117 00000000 100000000 38 00 00 02 0 1 0 00 0 00002002 00002002
0 0 00001000 0000000f 00000000 100000000 38 00 00 00 0 0 3 00 0 00001000 00001004
0 0 00001000 0000007f 00000000 100000000 38 00 00 00 0 0 0 00 4 00001000 00001004
0 0 00001000 045201b3 00000000 100000000 38 00 00 00 0 0 0 00 4 00001842 00001004
0 0 00001000 000290e7 00000000 100000000 38 00 00 00 0 0 3 00 4 00001800 00001004
0 0 00001000 000000f3 00000000 100000000 38 00 00 00 0 0 3 41 4 00001800 00001004
0 0 00001000 3000c173 00000000 100000000 38 00 00 00 0 0 1 60 4 00001302 00001004
1 0 00001000 011201b3 00000000 100000000 38 00 00 00 0 0 0 00 4 00001802 00001004
0 0 00001000 011201b3 00000000 100000000 38 04 11 03 3 1 0 00 0 00001802 00001004
0 0 00001000 00000073 00000000 100000000 38 00 00 00 0 0 3 41 0 00001000 00001004
0 0 00001000 00100073 00000000 100000000 38 00 00 00 0 0 3 42 0 00001000 00001004
0 0 00001000 30200073 00000000 100000000 38 00 00 00 0 0 3 50 0 00001300 00001004
0 0 00001000 7b200073 00000000 100000000 38 00 00 00 0 0 3 48 0 000017a0 00001004
0 0 00001000 10500073 00000000 100000000 38 00 00 00 0 0 3 44 0 00001100 00001004
0 0 00001000 30009173 00000000 100000000 38 01 00 02 1 1 1 60 0 00001302 00001004
0 0 00001000 30002173 00000000 100000000 38 00 00 02 1 1 1 00 0 00001302 00001004
1 0 00000ff0 00510093 00001000 000002000 38 02 00 01 1 1 0 00 2 000017f0 00000ff4
1 0 00001ffd 00510093 00001000 000002000 38 02 00 01 1 1 0 00 2 000027fd 00002001
1 1 00001ffd 00510093 00001000 000002000 38 02 00 01 1 1 0 00 0 000027fd 00001fff
1 0 fffffffe 00510093 00000000 100000000 38 02 00 01 1 1 0 00 0 000007fe 00000002
1 0 00001000 00510093 00000000 100000000 18 02 00 01 1 1 0 00 1 00001800 00001004
1 0 00001000 30200073 00000000 100000000 28 00 00 00 0 0 3 50 1 00001300 00001004

/* idec.f */
src/idec_pkg.sv
src/fetch_rx.sv
src/insn_decode.sv
src/fetch_check.sv
src/issue_tx.sv
src/idec_top.sv
tb/idec_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f idec.f --top-module idec_tb -o idec_sim

out=$(./obj_dir/idec_sim)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
